/* hw/rv_alu.sv */
//////////////////////////////////////////////////
// Execute stage, ALU plus one result slot
// Shift amounts use operand B bits [4:0] only
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
  input  logic         clk,
  input  logic         rst_ni,
  rv_issue_if.execute  issue,
  rv_result_if.execute result
);

  word_t      alu_result;
  logic [4:0] shamt;
  logic       slot_ready;

  assign shamt = issue.operand_b[4:0];

  always_comb begin
    case (issue.alu_op)
      AluAdd:   alu_result = issue.operand_a + issue.operand_b;
      AluSub:   alu_result = issue.operand_a - issue.operand_b;
      AluSll:   alu_result = issue.operand_a << shamt;
      AluSlt: begin
        alu_result = {{(Xlen-1){1'b0}},
                      $signed(issue.operand_a) < $signed(issue.operand_b)};
      end
      AluSltu: begin
        alu_result = {{(Xlen-1){1'b0}}, issue.operand_a < issue.operand_b};
      end
      AluXor:   alu_result = issue.operand_a ^ issue.operand_b;
      AluSrl:   alu_result = issue.operand_a >> shamt;
      AluSra:   alu_result = word_t'($signed(issue.operand_a) >>> shamt);
      AluOr:    alu_result = issue.operand_a | issue.operand_b;
      AluAnd:   alu_result = issue.operand_a & issue.operand_b;
      AluPassB: alu_result = issue.operand_b;
      default:  alu_result = '0;
    endcase
  end

  // Slot takes new data when empty or draining this cycle
  assign slot_ready  = !result.valid || result.ready;
  assign issue.ready = slot_ready;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      result.valid <= 1'b0;
    end else if (slot_ready) begin
      result.valid <= issue.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (slot_ready) begin
      result.insn    <= issue.insn;
      result.rd_addr <= issue.rd_addr;
      result.rd_we   <= issue.rd_we;
      result.trap    <= issue.trap;
      result.wdata   <= alu_result;
    end
  end

endmodule

/* hw/rv_core_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, encodings and types of the core
// Only the RV32I subset listed in the opcodes below
// is decoded, everything else traps
//////////////////////////////////////////////////

package rv_core_pkg;

  localparam int unsigned Xlen    = 32;
  localparam int unsigned NumRegs = 32;

  // Vector types
  typedef logic [Xlen-1:0]            word_t;
  typedef logic [31:0]                insn_t;
  typedef logic [$clog2(NumRegs)-1:0] reg_addr_t;
  typedef logic [31:0]                order_t;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  localparam logic [6:0] OpcOp    = 7'b0110011;
  localparam logic [6:0] OpcOpImm = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;

  //////////////////////////////////////////////////
  // Funct3 encodings shared by OP and OP-IMM
  //////////////////////////////////////////////////

  localparam logic [2:0] F3Add  = 3'b000;
  localparam logic [2:0] F3Sll  = 3'b001;
  localparam logic [2:0] F3Slt  = 3'b010;
  localparam logic [2:0] F3Sltu = 3'b011;
  localparam logic [2:0] F3Xor  = 3'b100;
  localparam logic [2:0] F3Sr   = 3'b101;
  localparam logic [2:0] F3Or   = 3'b110;
  localparam logic [2:0] F3And  = 3'b111;

  // ALU operations, AluPassB forwards operand B for LUI
  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd,
    AluPassB
  } alu_op_e;

endpackage

/* hw/rv_decoder.sv */
//////////////////////////////////////////////////
// Decode stage with one issue slot
// RAW and WAW hazards stall the input stream until
// the pending register has been written back
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       rst_ni,
  input  logic       instr_valid_i,
  output logic       instr_ready_o,
  input  insn_t      instr_i,
  rv_issue_if.decode issue,
  input  logic       wb_we_i,
  input  reg_addr_t  wb_addr_i,
  input  word_t      wb_data_i
);

  // Shared funct3 mapping, alt selects SUB or SRA
  function automatic alu_op_e base_op(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      F3Add:   op = alt ? AluSub : AluAdd;
      F3Sll:   op = AluSll;
      F3Slt:   op = AluSlt;
      F3Sltu:  op = AluSltu;
      F3Xor:   op = AluXor;
      F3Sr:    op = alt ? AluSra : AluSrl;
      F3Or:    op = AluOr;
      default: op = AluAnd;
    endcase
    return op;
  endfunction

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  reg_addr_t          rs1;
  reg_addr_t          rs2;
  reg_addr_t          rd;
  word_t              rdata_a;
  word_t              rdata_b;
  word_t              operand_b;
  alu_op_e            alu_op;
  logic               legal;
  logic               uses_rs1;
  logic               uses_rs2;
  logic [NumRegs-1:0] pending_q;
  logic               hazard;
  logic               slot_ready;
  logic               accept;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  rv_regfile regfile_inst (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_addr_i),
    .wdata_i   (wb_data_i)
  );

  //////////////////////////////////////////////////
  // Instruction decode
  //////////////////////////////////////////////////

  always_comb begin
    alu_op    = AluAdd;
    operand_b = rdata_b;
    legal     = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    case (opcode)
      OpcOp: begin
        alu_op   = base_op(funct3, funct7[5]);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        legal    = (funct7 == 7'b0000000) ||
                   ((funct7 == 7'b0100000) && ((funct3 == F3Add) || (funct3 == F3Sr)));
      end
      OpcOpImm: begin
        // Upper imm bits act as funct7 only for shifts
        alu_op    = base_op(funct3, funct7[5] && (funct3 == F3Sr));
        operand_b = {{(Xlen-12){instr_i[31]}}, instr_i[31:20]};
        uses_rs1  = 1'b1;
        if (funct3 == F3Sll) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == F3Sr) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          legal = 1'b1;
        end
      end
      OpcLui: begin
        alu_op    = AluPassB;
        operand_b = {instr_i[31:12], 12'b0};
        legal     = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Hazard check and handshake
  //////////////////////////////////////////////////

  assign hazard = (uses_rs1 && pending_q[rs1]) ||
                  (uses_rs2 && pending_q[rs2]) ||
                  (legal && pending_q[rd]);

  assign slot_ready    = !issue.valid || issue.ready;
  assign instr_ready_o = slot_ready && !hazard;
  assign accept        = instr_valid_i && instr_ready_o;

  // x0 is never marked, a stalled rd cannot collide with the clear
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      if (wb_we_i) begin
        pending_q[wb_addr_i] <= 1'b0;
      end
      if (accept && legal && (rd != '0)) begin
        pending_q[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      issue.valid <= 1'b0;
    end else if (slot_ready) begin
      issue.valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue.insn      <= instr_i;
      issue.alu_op    <= alu_op;
      issue.operand_a <= rdata_a;
      issue.operand_b <= operand_b;
      issue.rd_addr   <= rd;
      issue.rd_we     <= legal;
      issue.trap      <= !legal;
    end
  end

endmodule

/* hw/rv_int_core.sv */
//////////////////////////////////////////////////
// Integer core top, instruction stream in and
// retirement records out, both valid/ready
// Latency is three edges when nothing stalls
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_int_core import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  output logic      instr_ready_o,
  input  insn_t     instr_i,
  output logic      ret_valid_o,
  input  logic      ret_ready_i,
  output order_t    ret_order_o,
  output insn_t     ret_insn_o,
  output reg_addr_t ret_rd_addr_o,
  output word_t     ret_rd_wdata_o,
  output logic      ret_trap_o
);

  // Write-back path from retirement to decode
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  rv_issue_if  issue_if ();
  rv_result_if result_if ();

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////

  rv_decoder decoder_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .issue         (issue_if.decode),
    .wb_we_i       (wb_we),
    .wb_addr_i     (wb_addr),
    .wb_data_i     (wb_data)
  );

  rv_alu alu_inst (
    .clk    (clk),
    .rst_ni (rst_ni),
    .issue  (issue_if.execute),
    .result (result_if.execute)
  );

  rv_retire retire_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .result         (result_if.retire),
    .ret_valid_o    (ret_valid_o),
    .ret_ready_i    (ret_ready_i),
    .ret_order_o    (ret_order_o),
    .ret_insn_o     (ret_insn_o),
    .ret_rd_addr_o  (ret_rd_addr_o),
    .ret_rd_wdata_o (ret_rd_wdata_o),
    .ret_trap_o     (ret_trap_o),
    .wb_we_o        (wb_we),
    .wb_addr_o      (wb_addr),
    .wb_data_o      (wb_data)
  );

endmodule

/* hw/rv_issue_if.sv */
//////////////////////////////////////////////////
// Decode to execute stream, valid/ready handshake
// Payload stays stable while valid waits for ready
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface rv_issue_if import rv_core_pkg::*; ();

  logic      valid;
  logic      ready;
  insn_t     insn;
  alu_op_e   alu_op;
  word_t     operand_a;
  word_t     operand_b;
  reg_addr_t rd_addr;
  logic      rd_we;
  logic      trap;

  modport decode (
    output valid, insn, alu_op, operand_a, operand_b, rd_addr, rd_we, trap,
    input  ready
  );

  modport execute (
    input  valid, insn, alu_op, operand_a, operand_b, rd_addr, rd_we, trap,
    output ready
  );

endinterface

/* hw/rv_regfile.sv */
//////////////////////////////////////////////////
// Register file, x0 reads as zero
// Reads are combinational with no write bypass
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  // Only x1..x31 are storage
  word_t regs_q [1:NumRegs-1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* hw/rv_result_if.sv */
//////////////////////////////////////////////////
// Execute to retirement stream, valid/ready
// Carries the computed result with its instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface rv_result_if import rv_core_pkg::*; ();

  logic      valid;
  logic      ready;
  insn_t     insn;
  reg_addr_t rd_addr;
  logic      rd_we;
  logic      trap;
  word_t     wdata;

  modport execute (
    output valid, insn, rd_addr, rd_we, trap, wdata,
    input  ready
  );

  modport retire (
    input  valid, insn, rd_addr, rd_we, trap, wdata,
    output ready
  );

endinterface

/* hw/rv_retire.sv */
//////////////////////////////////////////////////
// Retirement stage, holds the output record
// Write-back fires on the output transfer only
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_retire import rv_core_pkg::*; (
  input  logic        clk,
  input  logic        rst_ni,
  rv_result_if.retire result,
  output logic        ret_valid_o,
  input  logic        ret_ready_i,
  output order_t      ret_order_o,
  output insn_t       ret_insn_o,
  output reg_addr_t   ret_rd_addr_o,
  output word_t       ret_rd_wdata_o,
  output logic        ret_trap_o,
  output logic        wb_we_o,
  output reg_addr_t   wb_addr_o,
  output word_t       wb_data_o
);

  logic slot_ready;
  logic transfer;
  logic writes_rd;

  assign transfer      = ret_valid_o && ret_ready_i;
  assign slot_ready    = !ret_valid_o || ret_ready_i;
  assign result.ready  = slot_ready;

  // Trace shows zero rd and data unless a real register is written
  assign writes_rd = result.rd_we && (result.rd_addr != '0);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ret_valid_o <= 1'b0;
      ret_order_o <= '0;
    end else begin
      if (slot_ready) begin
        ret_valid_o <= result.valid;
      end
      if (transfer) begin
        ret_order_o <= ret_order_o + order_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (slot_ready) begin
      ret_insn_o     <= result.insn;
      ret_rd_addr_o  <= writes_rd ? result.rd_addr : '0;
      ret_rd_wdata_o <= writes_rd ? result.wdata : '0;
      ret_trap_o     <= result.trap;
    end
  end

  // rd is already zero for non-writing records
  assign wb_we_o   = transfer && (ret_rd_addr_o != '0);
  assign wb_addr_o = ret_rd_addr_o;
  assign wb_data_o = ret_rd_wdata_o;

endmodule

/* rv_int_core.f */
hw/rv_core_pkg.sv
hw/rv_issue_if.sv
hw/rv_result_if.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_retire.sv
hw/rv_int_core.sv
testbench/tb_rv_int_core.sv

/* testbench/tb_rv_int_core.sv */
//////////////////////////////////////////////////
// Testbench for the integer core
// A reference model predicts each retirement record
// and the ret_ready_i back-pressure is random
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rv_int_core import rv_core_pkg::*; ();

  localparam int unsigned NumTests      = 32;
  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned TimeoutCycles = NumTests * 40 + ResetCycles;

  typedef struct packed {
    order_t    order;
    insn_t     insn;
    reg_addr_t rd;
    word_t     wdata;
    logic      trap;
  } record_t;

  logic        clk;
  logic        rst_ni;
  logic        instr_valid_i;
  logic        instr_ready_o;
  insn_t       instr_i;
  logic        ret_valid_o;
  logic        ret_ready_i;
  order_t      ret_order_o;
  insn_t       ret_insn_o;
  reg_addr_t   ret_rd_addr_o;
  word_t       ret_rd_wdata_o;
  logic        ret_trap_o;

  insn_t       stim_table [NumTests];
  word_t       ref_regs [NumRegs];
  record_t     exp_q [$];
  logic [31:0] lfsr;
  int unsigned retired;

  rv_int_core rv_int_core_inst (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_i        (instr_i),
    .ret_valid_o    (ret_valid_o),
    .ret_ready_i    (ret_ready_i),
    .ret_order_o    (ret_order_o),
    .ret_insn_o     (ret_insn_o),
    .ret_rd_addr_o  (ret_rd_addr_o),
    .ret_rd_wdata_o (ret_rd_wdata_o),
    .ret_trap_o     (ret_trap_o)
  );

  //////////////////////////////////////////////////
  // Encoders, LFSR and reference model
  //////////////////////////////////////////////////

  function automatic insn_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OpcOp};
  endfunction

  function automatic insn_t i_type(int imm, int rs1, logic [2:0] f3, int rd);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], OpcOpImm};
  endfunction

  function automatic insn_t lui_word(int imm, int rd);
    return {imm[19:0], rd[4:0], OpcLui};
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // Executes one instruction on ref_regs in program order
  function automatic record_t model_insn(insn_t insn, order_t order);
    record_t    rec;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_imm;
    logic       alt;
    logic       ok;
    word_t      a;
    word_t      b;
    word_t      res;
    opc    = insn[6:0];
    f3     = insn[14:12];
    f7     = insn[31:25];
    is_imm = (opc == OpcOpImm);
    alt    = (f7 == 7'h20);
    a      = ref_regs[insn[19:15]];
    b      = is_imm ? {{20{insn[31]}}, insn[31:20]} : ref_regs[insn[24:20]];
    ok     = 1'b1;
    res    = '0;
    if (opc == OpcLui) begin
      res = {insn[31:12], 12'h000};
    end else if ((opc == OpcOp) || is_imm) begin
      if (is_imm) begin
        // Shift immediates carry funct7 in imm[11:5]
        if (f3 == F3Sll) ok = (f7 == 7'h00);
        if (f3 == F3Sr) ok = (f7 == 7'h00) || alt;
      end else begin
        ok = (f7 == 7'h00) || (alt && ((f3 == F3Add) || (f3 == F3Sr)));
      end
      case (f3)
        F3Add: begin
          if (alt && !is_imm) res = a - b;
          else res = a + b;
        end
        F3Sll:   res = a << b[4:0];
        F3Slt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        F3Sltu:  res = (a < b) ? 32'd1 : 32'd0;
        F3Xor:   res = a ^ b;
        F3Sr: begin
          if (alt) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        F3Or:    res = a | b;
        default: res = a & b;
      endcase
    end else begin
      ok = 1'b0;
    end
    rec.order = order;
    rec.insn  = insn;
    rec.trap  = !ok;
    rec.rd    = '0;
    rec.wdata = '0;
    if (ok && (insn[11:7] != 5'd0)) begin
      rec.rd                = insn[11:7];
      rec.wdata             = res;
      ref_regs[insn[11:7]]  = res;
    end
    return rec;
  endfunction

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic verify_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_order(input string name, input order_t got, input order_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Clock, back-pressure, monitor and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    lfsr        = 32'h2a47;
    ret_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      // OR of two bits keeps ready high about three quarters of the time
      ret_ready_i = next_rand_bit();
      ret_ready_i = ret_ready_i | next_rand_bit();
    end
  end

  always @(posedge clk) begin : ret_monitor
    record_t exp_rec;
    if (rst_ni && ret_valid_o && ret_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A record retired at %0t with no instruction outstanding", $time);
        abort_run();
      end else begin
        exp_rec = exp_q.pop_front();
        compare_order("ret_order_o", ret_order_o, exp_rec.order);
        check_word("ret_insn_o", ret_insn_o, exp_rec.insn);
        verify_addr("ret_rd_addr_o", ret_rd_addr_o, exp_rec.rd);
        check_word("ret_rd_wdata_o", ret_rd_wdata_o, exp_rec.wdata);
        expect_flag("ret_trap_o", ret_trap_o, exp_rec.trap);
        retired++;
      end
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout, only %0d of %0d instructions retired", retired, NumTests);
    abort_run();
  end

  //////////////////////////////////////////////////
  // Stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    retired       = 0;
    for (int r = 0; r < NumRegs; r++) begin
      ref_regs[r] = '0;
    end
    stim_table = '{
      i_type(100, 0, F3Add, 1),               // x1 = 100
      i_type(-7, 0, F3Add, 2),                // negative immediate
      r_type(7'h00, 2, 1, F3Add, 3),
      r_type(7'h20, 1, 2, F3Add, 4),          // SUB
      r_type(7'h00, 1, 1, F3Sll, 5),          // shift by 100 mod 32
      r_type(7'h00, 1, 2, F3Slt, 6),
      r_type(7'h00, 1, 2, F3Sltu, 7),
      r_type(7'h00, 2, 1, F3Xor, 8),
      r_type(7'h00, 1, 2, F3Sr, 9),           // SRL
      r_type(7'h20, 1, 2, F3Sr, 10),          // SRA
      r_type(7'h00, 2, 1, F3Or, 11),
      r_type(7'h00, 2, 1, F3And, 12),
      lui_word('hABCDE, 13),
      i_type('h123, 13, F3Or, 14),
      i_type(-1, 13, F3Xor, 15),
      i_type('h0F0, 2, F3And, 16),
      i_type(-3, 2, F3Slt, 17),
      i_type(-1, 1, F3Sltu, 18),
      i_type(27, 1, F3Sll, 19),
      i_type(12, 13, F3Sr, 20),               // SRLI
      i_type('h408, 13, F3Sr, 21),            // SRAI by 8
      i_type(5, 1, F3Add, 0),                 // write to x0
      r_type(7'h00, 1, 0, F3Add, 22),         // x0 still reads zero
      32'h0000_0000,                          // unknown opcode
      r_type(7'h01, 2, 1, F3Add, 23),         // bad funct7
      i_type('h403, 1, F3Sll, 23),            // bad shift funct7
      r_type(7'h00, 0, 23, F3Add, 24),        // x23 untouched by traps
      i_type(3, 0, F3Add, 25),
      r_type(7'h00, 25, 25, F3Add, 25),       // dependent chain on x25
      r_type(7'h00, 25, 25, F3Add, 25),
      r_type(7'h20, 25, 1, F3Add, 26),
      i_type(-1, 26, F3Xor, 26)
    };

    repeat (ResetCycles) begin
      @(negedge clk);
      expect_flag("ret_valid_o", ret_valid_o, 1'b0);
    end
    rst_ni = 1'b1;
    @(negedge clk);
    expect_flag("ret_valid_o", ret_valid_o, 1'b0);
    // Empty slots accept at once after reset
    expect_flag("instr_ready_o", instr_ready_o, 1'b1);

    for (int i = 0; i < NumTests; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      instr_valid_i = 1'b1;
      instr_i       = stim_table[i];
      exp_q.push_back(model_insn(stim_table[i], order_t'(i)));
      @(posedge clk);
      while (!instr_ready_o) begin
        @(posedge clk);
      end
    end
    @(negedge clk);
    instr_valid_i = 1'b0;

    wait (retired == NumTests);
    // Extra records would show up in the monitor here
    repeat (10) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule
